//--- hdl/isa_pkg.sv
package isa_pkg;

	// datapath width
	localparam int WORD_W = 32;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [4:0] shamt_t;
	typedef logic [15:0] imm16_t;

	// execute operations, alu group first
	typedef enum logic [4:0] {
		ADD,
		ADDU,
		SUB,
		SUBU,
		AND,
		OR,
		XOR,
		NOR,
		SLT,
		SLTU,
		SLL,
		SRL,
		SRA,
		LUI,
		// divider and hi/lo group
		DIV,
		DIVU,
		MTHI,
		MTLO,
		MFHI,
		MFLO
	} alu_op_t;

	// second alu operand source
	typedef enum logic [1:0] {
		SRC_REG,
		SRC_SIGN_IMM,
		SRC_ZERO_IMM
	} src2_sel_t;

	typedef enum logic {
		SA_FIELD,
		SA_REG
	} sa_sel_t;

endpackage

//--- hdl/pipe_pkg.sv
package pipe_pkg;

	import isa_pkg::*;

	// load cycle plus one cycle per quotient bit
	localparam int DIV_CYCLES = 33;
	localparam int DIV_CNT_W = $clog2(DIV_CYCLES);

	typedef logic [DIV_CNT_W-1:0] div_cnt_t;

	// decoded instruction handed to execute
	typedef struct packed {
		alu_op_t   op;
		word_t     src1;
		word_t     src2;
		imm16_t    imm;
		src2_sel_t src2_sel;
		sa_sel_t   sa_sel;
		shamt_t    shamt;
		reg_idx_t  waddr;
	} ex_req_t;

	// issue stage to commit stage
	typedef struct packed {
		alu_op_t  op;
		word_t    alu_result;
		logic     overflow;
		reg_idx_t waddr;
		word_t    src1;
	} ex_to_wb_t;

	typedef struct packed {
		word_t quotient;
		word_t remainder;
	} div_res_t;

	// retired register write
	typedef struct packed {
		logic     wen;
		reg_idx_t waddr;
		word_t    wdata;
	} wb_out_t;

endpackage

//--- hdl/alu.sv
`timescale 1ns/1ps
module alu (
	input  isa_pkg::alu_op_t op,
	input  isa_pkg::word_t   a,
	input  isa_pkg::word_t   b,
	input  isa_pkg::shamt_t  sa,
	output isa_pkg::word_t   result,
	output logic             overflow
);
	import isa_pkg::*;

	word_t      sum;
	word_t      diff;
	logic [32:0] diff_ext;
	logic       add_ovf;
	logic       sub_ovf;
	logic       less_signed;
	logic       less_unsigned;

	assign sum = a + b;
	assign diff_ext = {1'b0, a} - {1'b0, b};
	assign diff = diff_ext[31:0];

	// same-sign inputs with a flipped sign out
	assign add_ovf = (a[31] == b[31]) && (sum[31] != a[31]);
	assign sub_ovf = (a[31] != b[31]) && (diff[31] != a[31]);

	// sign of the difference corrected by overflow
	assign less_signed = diff[31] ^ sub_ovf;
	// borrow out of the widened subtract
	assign less_unsigned = diff_ext[32];

	always_comb
	begin
		case (op)
			ADD, ADDU: result = sum;
			SUB, SUBU: result = diff;
			AND:       result = a & b;
			OR:        result = a | b;
			XOR:       result = a ^ b;
			NOR:       result = ~(a | b);
			SLT:       result = {31'd0, less_signed};
			SLTU:      result = {31'd0, less_unsigned};
			SLL:       result = b << sa;
			SRL:       result = b >> sa;
			SRA:       result = $signed(b) >>> sa;
			LUI:       result = {b[15:0], 16'd0};
			default:   result = '0;
		endcase
	end

	// only the trapping forms report overflow
	always_comb
	begin
		case (op)
			ADD:     overflow = add_ovf;
			SUB:     overflow = sub_ovf;
			default: overflow = 1'b0;
		endcase
	end

endmodule

//--- hdl/div_unit.sv
`timescale 1ns/1ps
module div_unit (
	input  logic               clk,
	input  logic               resetn,
	input  logic               start,
	input  logic               is_signed,
	input  isa_pkg::word_t     a,
	input  isa_pkg::word_t     b,
	output logic               done,
	output pipe_pkg::div_res_t res
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic        busy;
	div_cnt_t    count;
	word_t       quot;
	word_t       rem;
	word_t       divisor;
	logic        q_neg;
	logic        r_neg;
	word_t       a_mag;
	word_t       b_mag;
	logic [32:0] trial;
	logic        load;

	assign load = start && !busy;

	// magnitudes of the signed operands
	assign a_mag = (is_signed && a[31]) ? -a : a;
	assign b_mag = (is_signed && b[31]) ? -b : b;

	// partial remainder shifted by one bit, minus divisor
	assign trial = {rem, quot[31]} - {1'b0, divisor};

	assign done = busy && (count == div_cnt_t'(DIV_CYCLES - 1));

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			busy <= 1'b0;
			count <= '0;
		end
		else if (load)
		begin
			busy <= 1'b1;
			count <= '0;
		end
		else if (done)
		begin
			busy <= 1'b0;
		end
		else if (busy)
		begin
			count <= count + 1'b1;
		end
	end

	// dividend shifts out of quot as quotient bits shift in
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			quot <= a_mag;
			rem <= '0;
			divisor <= b_mag;
			q_neg <= is_signed && (a[31] ^ b[31]);
			r_neg <= is_signed && a[31];
		end
		else if (busy && !done)
		begin
			if (!trial[32])
			begin
				rem <= trial[31:0];
				quot <= {quot[30:0], 1'b1};
			end
			else
			begin
				rem <= {rem[30:0], quot[31]};
				quot <= {quot[30:0], 1'b0};
			end
		end
	end

	// remainder follows the dividend sign
	assign res.quotient = q_neg ? -quot : quot;
	assign res.remainder = r_neg ? -rem : rem;

endmodule

//--- hdl/ex_issue.sv
`timescale 1ns/1ps
module ex_issue (
	input  logic                clk,
	input  logic                resetn,
	input  logic                in_valid,
	input  pipe_pkg::ex_req_t   in_req,
	input  isa_pkg::word_t      alu_result,
	input  logic                alu_overflow,
	input  logic                div_done,
	input  logic                wb_allowin,
	output logic                in_allowin,
	output isa_pkg::alu_op_t    alu_op,
	output isa_pkg::word_t      alu_a,
	output isa_pkg::word_t      alu_b,
	output isa_pkg::shamt_t     alu_sa,
	output logic                div_start,
	output logic                div_signed,
	output isa_pkg::word_t      div_a,
	output isa_pkg::word_t      div_b,
	output logic                ex_valid,
	output pipe_pkg::ex_to_wb_t ex_out
);
	import isa_pkg::*;

	logic              valid;
	pipe_pkg::ex_req_t req;
	logic              is_div;
	logic              div_complete;
	logic              ready_go;

	assign is_div = (req.op == DIV) || (req.op == DIVU);

	// a divide waits for the divider, everything else goes at once
	assign ready_go = !is_div || div_done || div_complete;
	assign in_allowin = !valid || (ready_go && wb_allowin);
	assign ex_valid = valid && ready_go;

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			valid <= 1'b0;
		end
		else if (in_allowin)
		begin
			valid <= in_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (in_valid && in_allowin)
		begin
			req <= in_req;
		end
	end

	// remembers a finished divide stalled by commit
	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			div_complete <= 1'b0;
		end
		else if (in_allowin)
		begin
			div_complete <= 1'b0;
		end
		else if (div_done)
		begin
			div_complete <= 1'b1;
		end
	end

	assign div_start = valid && is_div && !div_complete;
	assign div_signed = (req.op == DIV);
	assign div_a = req.src1;
	assign div_b = req.src2;

	assign alu_op = req.op;
	assign alu_a = req.src1;

	always_comb
	begin
		case (req.src2_sel)
			SRC_SIGN_IMM: alu_b = {{16{req.imm[15]}}, req.imm};
			SRC_ZERO_IMM: alu_b = {16'd0, req.imm};
			default:      alu_b = req.src2;
		endcase
	end

	// variable shifts take rs[4:0]
	assign alu_sa = (req.sa_sel == SA_REG) ? req.src1[4:0] : req.shamt;

	assign ex_out.op = req.op;
	assign ex_out.alu_result = alu_result;
	assign ex_out.overflow = alu_overflow;
	assign ex_out.waddr = req.waddr;
	assign ex_out.src1 = req.src1;

endmodule

//--- hdl/wb_commit.sv
`timescale 1ns/1ps
module wb_commit (
	input  logic                clk,
	input  logic                resetn,
	input  logic                ex_valid,
	input  pipe_pkg::ex_to_wb_t ex_in,
	input  pipe_pkg::div_res_t  div_res,
	input  logic                out_allowin,
	output logic                wb_allowin,
	output logic                out_valid,
	output pipe_pkg::wb_out_t   out_wb
);
	import isa_pkg::*;
	import pipe_pkg::*;

	word_t   hi;
	word_t   lo;
	wb_out_t next_wb;
	logic    accept;

	assign wb_allowin = !out_valid || out_allowin;
	assign accept = ex_valid && wb_allowin;

	always_comb
	begin
		next_wb.waddr = ex_in.waddr;
		next_wb.wdata = ex_in.alu_result;
		case (ex_in.op)
			DIV, DIVU, MTHI, MTLO:
			begin
				next_wb.wen = 1'b0;
			end
			MFHI:
			begin
				next_wb.wdata = hi;
				next_wb.wen = 1'b1;
			end
			MFLO:
			begin
				next_wb.wdata = lo;
				next_wb.wen = 1'b1;
			end
			default:
			begin
				// overflow is only ever set for add and sub
				next_wb.wen = !ex_in.overflow;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			out_valid <= 1'b0;
		end
		else if (wb_allowin)
		begin
			out_valid <= ex_valid;
		end
	end

	// held while downstream stalls
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			out_wb <= next_wb;
		end
	end

	// hi/lo written as the instruction enters commit
	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			hi <= '0;
			lo <= '0;
		end
		else if (accept)
		begin
			case (ex_in.op)
				DIV, DIVU:
				begin
					hi <= div_res.remainder;
					lo <= div_res.quotient;
				end
				MTHI: hi <= ex_in.src1;
				MTLO: lo <= ex_in.src1;
				default:
				begin
					hi <= hi;
					lo <= lo;
				end
			endcase
		end
	end

endmodule

//--- hdl/exec_core.sv
`timescale 1ns/1ps
module exec_core (
	input  logic              clk,
	input  logic              resetn,
	input  logic              in_valid,
	input  pipe_pkg::ex_req_t in_req,
	input  logic              out_allowin,
	output logic              in_allowin,
	output logic              out_valid,
	output pipe_pkg::wb_out_t out_wb
);
	import isa_pkg::*;
	import pipe_pkg::*;

	// issue to alu
	alu_op_t   alu_op;
	word_t     alu_a;
	word_t     alu_b;
	shamt_t    alu_sa;
	word_t     alu_result;
	logic      alu_overflow;

	// issue to divider
	logic      div_start;
	logic      div_signed;
	word_t     div_a;
	word_t     div_b;
	logic      div_done;
	div_res_t  div_res;

	logic      ex_valid;
	ex_to_wb_t ex_out;
	logic      wb_allowin;

	ex_issue u_ex_issue (
		.clk          (clk),
		.resetn       (resetn),
		.in_valid     (in_valid),
		.in_req       (in_req),
		.alu_result   (alu_result),
		.alu_overflow (alu_overflow),
		.div_done     (div_done),
		.wb_allowin   (wb_allowin),
		.in_allowin   (in_allowin),
		.alu_op       (alu_op),
		.alu_a        (alu_a),
		.alu_b        (alu_b),
		.alu_sa       (alu_sa),
		.div_start    (div_start),
		.div_signed   (div_signed),
		.div_a        (div_a),
		.div_b        (div_b),
		.ex_valid     (ex_valid),
		.ex_out       (ex_out)
	);

	alu u_alu (
		.op       (alu_op),
		.a        (alu_a),
		.b        (alu_b),
		.sa       (alu_sa),
		.result   (alu_result),
		.overflow (alu_overflow)
	);

	div_unit u_div_unit (
		.clk       (clk),
		.resetn    (resetn),
		.start     (div_start),
		.is_signed (div_signed),
		.a         (div_a),
		.b         (div_b),
		.done      (div_done),
		.res       (div_res)
	);

	wb_commit u_wb_commit (
		.clk         (clk),
		.resetn      (resetn),
		.ex_valid    (ex_valid),
		.ex_in       (ex_out),
		.div_res     (div_res),
		.out_allowin (out_allowin),
		.wb_allowin  (wb_allowin),
		.out_valid   (out_valid),
		.out_wb      (out_wb)
	);

endmodule

//--- verif/clk_rst_gen.sv
`timescale 1ns/1ps
module clk_rst_gen (
	output logic clk,
	output logic resetn
);

	// 4 ns period
	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// low across two rising edges, released away from the edge
	initial
	begin
		resetn = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
	end

endmodule

//--- verif/exec_core_props.sv
`timescale 1ns/1ps
module exec_core_props (
	input logic              clk,
	input logic              resetn,
	input logic              in_allowin,
	input logic              out_valid,
	input logic              out_allowin,
	input logic              div_start,
	input logic              div_done,
	input pipe_pkg::wb_out_t out_wb
);

	// number of failed properties so far
	int fail_count = 0;

	// a stalled result stays put until taken
	property p_hold_stable;
		@(posedge clk) disable iff (!resetn)
		out_valid && !out_allowin |=> out_valid && $stable(out_wb);
	endproperty

	// an unfinished divide blocks the issue register
	property p_div_blocks_issue;
		@(posedge clk) disable iff (!resetn)
		div_start && !div_done |-> !in_allowin;
	endproperty

	property p_reset_clears_output;
		@(posedge clk) !resetn |=> !out_valid;
	endproperty

	assert property (p_hold_stable)
		else
		begin
			$error("out_wb changed or dropped while stalled");
			fail_count++;
		end
	assert property (p_div_blocks_issue)
		else
		begin
			$error("in_allowin high while a divide is still running");
			fail_count++;
		end
	assert property (p_reset_clears_output)
		else
		begin
			$error("out_valid high in the cycle after reset");
			fail_count++;
		end

endmodule

//--- verif/exec_core_tb.sv
`timescale 1ns/1ps
module exec_core_tb;
	import isa_pkg::*;
	import pipe_pkg::*;

	logic    clk;
	logic    resetn;
	logic    in_valid;
	ex_req_t in_req;
	logic    out_allowin;
	logic    in_allowin;
	logic    out_valid;
	wb_out_t out_wb;

	integer  seed;
	int      accept_count;
	int      retire_count;
	wb_out_t exp_q[$];
	wb_out_t exp_wb;
	wb_out_t held_wb;
	logic    held;
	word_t   model_hi;
	word_t   model_lo;

	// stall pattern for out_allowin
	logic          bp_on;
	logic [1023:0] stall_pat;
	logic [9:0]    bp_cycle;

	clk_rst_gen u_clk_rst_gen (
		.clk    (clk),
		.resetn (resetn)
	);

	exec_core u_exec_core (
		.clk         (clk),
		.resetn      (resetn),
		.in_valid    (in_valid),
		.in_req      (in_req),
		.out_allowin (out_allowin),
		.in_allowin  (in_allowin),
		.out_valid   (out_valid),
		.out_wb      (out_wb)
	);

	bind exec_core exec_core_props u_exec_core_props (
		.clk         (clk),
		.resetn      (resetn),
		.in_allowin  (in_allowin),
		.out_valid   (out_valid),
		.out_allowin (out_allowin),
		.div_start   (div_start),
		.div_done    (div_done),
		.out_wb      (out_wb)
	);

	task automatic report_mismatch(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic report_error(input string msg);
		$display("ERROR t=%0t %s", $time, msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	// expected retirement from the MIPS rules, hi/lo kept in program order
	function automatic wb_out_t ref_exec(input ex_req_t r, inout word_t hi, inout word_t lo);
		word_t       a;
		word_t       b;
		shamt_t      sa;
		logic [32:0] wide;
		wb_out_t     w;
		a = r.src1;
		case (r.src2_sel)
			SRC_SIGN_IMM: b = {{16{r.imm[15]}}, r.imm};
			SRC_ZERO_IMM: b = {16'h0000, r.imm};
			default:      b = r.src2;
		endcase
		sa = (r.sa_sel == SA_REG) ? a[4:0] : r.shamt;
		w.wen = 1'b1;
		w.waddr = r.waddr;
		w.wdata = '0;
		case (r.op)
			ADD:
			begin
				wide = {a[31], a} + {b[31], b};
				w.wdata = wide[31:0];
				w.wen = (wide[32] == wide[31]);
			end
			SUB:
			begin
				wide = {a[31], a} - {b[31], b};
				w.wdata = wide[31:0];
				w.wen = (wide[32] == wide[31]);
			end
			ADDU: w.wdata = a + b;
			SUBU: w.wdata = a - b;
			AND:  w.wdata = a & b;
			OR:   w.wdata = a | b;
			XOR:  w.wdata = a ^ b;
			NOR:  w.wdata = ~(a | b);
			SLT:  w.wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			SLTU: w.wdata = (a < b) ? 32'd1 : 32'd0;
			SLL:  w.wdata = b << sa;
			SRL:  w.wdata = b >> sa;
			SRA:  w.wdata = $signed(b) >>> sa;
			LUI:  w.wdata = {r.imm, 16'h0000};
			DIV:
			begin
				// truncating divide, remainder keeps the dividend sign
				lo = $signed(r.src1) / $signed(r.src2);
				hi = $signed(r.src1) % $signed(r.src2);
				w.wen = 1'b0;
			end
			DIVU:
			begin
				lo = r.src1 / r.src2;
				hi = r.src1 % r.src2;
				w.wen = 1'b0;
			end
			MTHI:
			begin
				hi = a;
				w.wen = 1'b0;
			end
			MTLO:
			begin
				lo = a;
				w.wen = 1'b0;
			end
			MFHI: w.wdata = hi;
			MFLO: w.wdata = lo;
			default: w.wen = 1'b0;
		endcase
		return w;
	endfunction

	function automatic ex_req_t make_req(input alu_op_t op, input word_t s1, input word_t s2,
			input reg_idx_t wa);
		ex_req_t r;
		r = '0;
		r.op = op;
		r.src1 = s1;
		r.src2 = s2;
		r.src2_sel = SRC_REG;
		r.sa_sel = SA_FIELD;
		r.waddr = wa;
		return r;
	endfunction

	function automatic ex_req_t random_alu_req();
		ex_req_t r;
		r.op = alu_op_t'($unsigned($random(seed)) % 14);
		r.src1 = $random(seed);
		r.src2 = $random(seed);
		r.imm = imm16_t'($random(seed));
		r.src2_sel = src2_sel_t'($unsigned($random(seed)) % 3);
		r.sa_sel = sa_sel_t'($random(seed) & 1);
		r.shamt = shamt_t'($random(seed));
		r.waddr = reg_idx_t'($random(seed));
		// equal operands now and then for the compares
		if (($random(seed) & 7) == 0)
		begin
			r.src2 = r.src1;
		end
		if (r.op == LUI)
		begin
			r.src2_sel = SRC_ZERO_IMM;
		end
		return r;
	endfunction

	function automatic ex_req_t random_div_req();
		ex_req_t r;
		word_t   a;
		word_t   b;
		alu_op_t op;
		op = ($random(seed) & 1) ? DIV : DIVU;
		a = $random(seed);
		b = $random(seed);
		// small divisors too, sign kept
		if ($random(seed) & 1)
		begin
			b = $signed(b) >>> 20;
		end
		if (b == 0)
		begin
			b = 32'd7;
		end
		if (op == DIV && a == 32'h8000_0000 && b == 32'hffff_ffff)
		begin
			b = 32'd3;
		end
		r = make_req(op, a, b, 5'd0);
		return r;
	endfunction

	function automatic ex_req_t random_mixed_req();
		ex_req_t r;
		int      pick;
		pick = $unsigned($random(seed)) % 16;
		r = random_alu_req();
		if (pick == 0)
		begin
			r = random_div_req();
		end
		else if (pick == 1)
		begin
			r.op = ($random(seed) & 1) ? MTHI : MTLO;
		end
		else if (pick == 2)
		begin
			r.op = ($random(seed) & 1) ? MFHI : MFLO;
		end
		return r;
	endfunction

	// called on a falling edge, returns on the falling edge after acceptance
	task automatic issue(input ex_req_t r);
		int target;
		int n;
		target = accept_count + 1;
		n = 0;
		in_valid = 1'b1;
		in_req = r;
		while (accept_count < target)
		begin
			@(negedge clk);
			n++;
			if (n > 500)
			begin
				report_error("instruction was never accepted");
			end
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		in_valid = 1'b0;
		while (exp_q.size() != 0 || out_valid)
		begin
			@(negedge clk);
			n++;
			if (n > 4000)
			begin
				report_error("pipeline did not drain");
			end
		end
	endtask

	task automatic check_latency(input ex_req_t r, input int expected);
		int cycles;
		drain();
		issue(r);
		in_valid = 1'b0;
		cycles = 0;
		while (!out_valid)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > expected + 20)
			begin
				report_error("out_valid never rose after acceptance");
			end
		end
		assert (cycles == expected)
			else report_mismatch("latency", expected, cycles);
	endtask

	task automatic run_overflow();
		word_t ova[4];
		word_t ovb[4];
		int    i;
		ova = '{32'h7fff_ffff, 32'h8000_0000, 32'h8000_0000, 32'h7fff_ffff};
		ovb = '{32'h0000_0001, 32'hffff_ffff, 32'h0000_0001, 32'hffff_ffff};
		for (i = 0; i < 4; i++)
		begin
			issue(make_req((i < 2) ? ADD : SUB, ova[i], ovb[i], 5'd3));
			issue(make_req((i < 2) ? ADDU : SUBU, ova[i], ovb[i], 5'd4));
		end
		drain();
	endtask

	task automatic run_divides();
		int i;
		issue(make_req(DIV, -32'sd7, 32'd2, 5'd0));
		issue(make_req(MFHI, 0, 0, 5'd8));
		issue(make_req(MFLO, 0, 0, 5'd9));
		issue(make_req(DIV, 32'd7, -32'sd2, 5'd0));
		issue(make_req(MFHI, 0, 0, 5'd8));
		issue(make_req(MFLO, 0, 0, 5'd9));
		issue(make_req(DIVU, -32'sd7, 32'd2, 5'd0));
		issue(make_req(MFLO, 0, 0, 5'd9));
		for (i = 0; i < 40; i++)
		begin
			issue(random_div_req());
			issue(make_req(MFHI, 0, 0, 5'd10));
			issue(make_req(MFLO, 0, 0, 5'd11));
		end
		drain();
	endtask

	task automatic run_hilo();
		issue(make_req(MTHI, 32'h1234_5678, 0, 5'd0));
		issue(make_req(MTLO, 32'h9abc_def0, 0, 5'd0));
		issue(make_req(MFHI, 0, 0, 5'd12));
		issue(make_req(MFLO, 0, 0, 5'd13));
		// the divide lands after the moves
		issue(make_req(MTHI, 32'h0bad_0bad, 0, 5'd0));
		issue(make_req(MTLO, 32'h0dd0_0dd0, 0, 5'd0));
		issue(make_req(DIVU, 32'd1000, 32'd7, 5'd0));
		issue(make_req(MFHI, 0, 0, 5'd12));
		issue(make_req(MFLO, 0, 0, 5'd13));
		drain();
	endtask

	always @(negedge clk)
	begin
		if (bp_on)
		begin
			out_allowin = stall_pat[bp_cycle];
		end
		else
		begin
			out_allowin = 1'b1;
		end
		bp_cycle = bp_cycle + 1'b1;
	end

	always @(negedge clk)
	begin
		if (u_exec_core.u_exec_core_props.fail_count != 0)
		begin
			report_error("a bound assertion in exec_core_props failed");
		end
	end

	// retirement compare, then acceptance into the expected queue
	always @(posedge clk)
	begin
		if (resetn)
		begin
			if (held)
			begin
				assert (out_wb === held_wb)
					else report_mismatch("out_wb", held_wb, out_wb);
			end
			if (out_valid && out_allowin)
			begin
				assert (exp_q.size() > 0)
					else report_error("result retired with no instruction outstanding");
				exp_wb = exp_q.pop_front();
				retire_count++;
				assert (out_wb.wen === exp_wb.wen)
					else report_mismatch("out_wb.wen", exp_wb.wen, out_wb.wen);
				if (exp_wb.wen)
				begin
					assert (out_wb.waddr === exp_wb.waddr)
						else report_mismatch("out_wb.waddr", exp_wb.waddr, out_wb.waddr);
					assert (out_wb.wdata === exp_wb.wdata)
						else report_mismatch("out_wb.wdata", exp_wb.wdata, out_wb.wdata);
				end
			end
			held = out_valid && !out_allowin;
			held_wb = out_wb;
			if (in_valid && in_allowin)
			begin
				exp_wb = ref_exec(in_req, model_hi, model_lo);
				exp_q.push_back(exp_wb);
				accept_count++;
			end
		end
	end

	initial
	begin
		int n;
		in_valid = 1'b0;
		in_req = '0;
		out_allowin = 1'b1;
		bp_on = 1'b0;
		bp_cycle = '0;
		held = 1'b0;
		seed = 32'hb8b4;
		accept_count = 0;
		retire_count = 0;
		model_hi = '0;
		model_lo = '0;
		for (n = 0; n < 1024; n++)
		begin
			stall_pat[n] = ($random(seed) & 1) != 0;
		end
		n = 0;
		while (resetn !== 1'b1)
		begin
			@(negedge clk);
			n++;
			if (n > 20)
			begin
				report_error("reset was never released");
			end
		end
		assert (out_valid === 1'b0)
			else report_mismatch("out_valid", 0, out_valid);
		assert (in_allowin === 1'b1)
			else report_mismatch("in_allowin", 1, in_allowin);
		check_latency(make_req(ADD, 32'd1, 32'd2, 5'd1), 1);
		check_latency(make_req(DIV, 32'd100, 32'd7, 5'd0), DIV_CYCLES + 1);
		repeat (300) issue(random_alu_req());
		drain();
		run_overflow();
		run_divides();
		run_hilo();
		// random stalls on the output
		bp_on = 1'b1;
		repeat (200) issue(random_mixed_req());
		drain();
		bp_on = 1'b0;
		assert (retire_count == accept_count)
			else report_mismatch("retire count", accept_count, retire_count);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- filelist.f
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/alu.sv
hdl/div_unit.sv
hdl/ex_issue.sv
hdl/wb_commit.sv
hdl/exec_core.sv
verif/clk_rst_gen.sv
verif/exec_core_props.sv
verif/exec_core_tb.sv
